// ==== rtl/ics307Pkg.sv ====
`default_nettype none

package ics307Pkg;

    // Synthesizer count and serial frame geometry.
    localparam int pllCount       = 3;
    localparam int frameBits      = 132;
    localparam int frameCountBits = $clog2(frameBits);
    localparam int zeroGapBits    = 36;    // Bits 32 to 67 are always loaded as zero.

    // Serial clock runs at busClk divided by this even number.
    localparam int sckDivider   = 4;
    localparam int sckCountBits = $clog2(sckDivider);

    // Bus decoding.
    localparam int laneCount = 4;
    localparam logic [7:0] pllSpaceBase = 8'h50;   // Compared against addr[12:5].

    localparam logic [2:0] regBitsLow  = 3'd0;
    localparam logic [2:0] regBitsMid  = 3'd1;
    localparam logic [2:0] regBitsHigh = 3'd2;
    localparam logic [2:0] regControl  = 3'd3;
    localparam logic [2:0] regXfer     = 3'd4;

    // Control word bit positions. The done bit ignores writes.
    localparam int ctlEnableBit = 0;
    localparam int ctlDoneBit   = 1;
    localparam int ctlResetBit  = 2;

    typedef logic [31:0]           busWord;
    typedef logic [frameBits-1:0]  pllFrame;
    typedef logic [pllCount-1:0]   pllSelect;   // One bit per chip.

endpackage

`default_nettype wire

// ==== rtl/pllRegBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module pllRegBank (
    input  wire                      busClk,
    input  wire                      xferDone,
    input  wire [12:0]               addr,
    input  wire ics307Pkg::busWord   dataIn,
    input  wire                      wr0,
    input  wire                      wr1,
    input  wire                      wr2,
    input  wire                      wr3,
    input  wire                      startReady,
    input  wire                      loadDone,
    input  wire ics307Pkg::pllSelect loadSel,
    output ics307Pkg::busWord        dataOut,
    output ics307Pkg::pllSelect      pllEn,
    output ics307Pkg::pllSelect      pllReset,
    output logic                     startValid,
    output ics307Pkg::pllSelect      startSel,
    output ics307Pkg::busWord        wordLow,
    output ics307Pkg::busWord        wordMid,
    output ics307Pkg::busWord        wordHigh
);

    import ics307Pkg::*;

    logic                 pllSpace;
    logic [1:0]           pllIdx;
    logic [2:0]           regOff;
    logic                 idxValid;
    logic                 cfgHit;
    logic [laneCount-1:0] laneWr;
    logic                 xferHit;
    pllSelect             xferSel;
    pllSelect             acceptSel;
    pllSelect             pending;
    pllSelect             doneFlag;

    busWord bitsLow  [pllCount];
    busWord bitsMid  [pllCount];
    busWord bitsHigh [pllCount];

    assign pllSpace = (addr[12:5] == pllSpaceBase);
    assign pllIdx   = addr[4:3];
    assign regOff   = addr[2:0];
    assign idxValid = (int'(pllIdx) < pllCount);   // Index 3 has no chip behind it.
    assign cfgHit   = pllSpace && idxValid;
    assign laneWr   = {wr3, wr2, wr1, wr0};

    // The transfer register fires on the top lane strobe.
    assign xferHit = cfgHit && wr3 && (regOff == regXfer);
    assign xferSel = xferHit ? pllSelect'(1) << pllIdx : '0;

    // Configuration words, one byte lane per write strobe.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            for (int i = 0; i < pllCount; i++) begin
                bitsLow[i]  <= '0;
                bitsMid[i]  <= '0;
                bitsHigh[i] <= '0;
            end
        end else if (cfgHit) begin
            for (int b = 0; b < laneCount; b++) begin
                if (laneWr[b]) begin
                    case (regOff)
                        regBitsLow:  bitsLow[pllIdx][8*b +: 8]  <= dataIn[8*b +: 8];
                        regBitsMid:  bitsMid[pllIdx][8*b +: 8]  <= dataIn[8*b +: 8];
                        regBitsHigh: bitsHigh[pllIdx][8*b +: 8] <= dataIn[8*b +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            pllEn    <= '0;
            pllReset <= '0;
        end else if (cfgHit && wr0 && (regOff == regControl)) begin
            pllEn[pllIdx]    <= dataIn[ctlEnableBit];
            pllReset[pllIdx] <= dataIn[ctlResetBit];
        end
    end

    assign acceptSel = (startValid && startReady) ? startSel : '0;

    // A fresh transfer write wins over an accept or a completion in the same cycle.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            pending  <= '0;
            doneFlag <= '0;
        end else begin
            pending  <= (pending & ~acceptSel) | xferSel;
            doneFlag <= (doneFlag | (loadDone ? loadSel : '0)) & ~xferSel;
        end
    end

    // Lowest chip number has priority.
    assign startValid = |pending;
    assign startSel   = pending & ~(pending - pllSelect'(1));

    always_comb begin
        wordLow  = '0;
        wordMid  = '0;
        wordHigh = '0;
        for (int i = 0; i < pllCount; i++) begin
            if (startSel[i]) begin
                wordLow  = bitsLow[i];
                wordMid  = bitsMid[i];
                wordHigh = bitsHigh[i];
            end
        end
    end

    always_comb begin
        dataOut = '0;
        if (cfgHit) begin
            case (regOff)
                regBitsLow:  dataOut = bitsLow[pllIdx];
                regBitsMid:  dataOut = bitsMid[pllIdx];
                regBitsHigh: dataOut = bitsHigh[pllIdx];
                regControl: begin
                    dataOut[ctlEnableBit] = pllEn[pllIdx];
                    dataOut[ctlDoneBit]   = doneFlag[pllIdx];
                    dataOut[ctlResetBit]  = pllReset[pllIdx];
                end
                default: dataOut = '0;   // Transfer and unused offsets read as zero.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sckGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sckGenerator (
    input  wire  busClk,
    input  wire  xferDone,
    input  wire  sckEnable,
    output logic sck,
    output logic sckRise,
    output logic sckFall
);

    import ics307Pkg::*;

    logic [sckCountBits-1:0] sckCount;

    // Free running down counter, one wrap per serial clock period.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            sckCount <= sckCountBits'(sckDivider - 1);
        end else if (sckCount == '0) begin
            sckCount <= sckCountBits'(sckDivider - 1);
        end else begin
            sckCount <= sckCount - 1'b1;
        end
    end

    assign sckRise = (sckCount == '0);
    assign sckFall = (sckCount == sckCountBits'(sckDivider / 2));   // Half a period after rise.

    // The pin only goes high while enabled, so a disable always parks it low.
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            sck <= 1'b0;
        end else if (sckRise && sckEnable) begin
            sck <= 1'b1;
        end else if (sckFall) begin
            sck <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ics307Serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ics307Serializer (
    input  wire                      busClk,
    input  wire                      xferDone,
    input  wire                      startValid,
    input  wire ics307Pkg::pllSelect startSel,
    input  wire ics307Pkg::busWord   wordLow,
    input  wire ics307Pkg::busWord   wordMid,
    input  wire ics307Pkg::busWord   wordHigh,
    input  wire                      sckRise,
    input  wire                      sckFall,
    output logic                     startReady,
    output logic                     sckEnable,
    output logic                     sdi,
    output ics307Pkg::pllSelect      pllCs,
    output logic                     loadDone,
    output ics307Pkg::pllSelect      loadSel
);

    import ics307Pkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stShift,
        stStrobe
    } loadState;

    loadState                  state;
    pllFrame                   frameInit;
    pllFrame                   shiftReg;
    logic [frameCountBits-1:0] bitCount;
    pllSelect                  chipSel;

    assign startReady = (state == stIdle);
    assign sdi        = shiftReg[frameBits-1];   // MSB first.

    // Frame capture happens at accept, so later register writes do not disturb a load.
    always_ff @(posedge busClk) begin
        if (startValid && startReady) begin
            frameInit <= {wordHigh, wordMid, {zeroGapBits{1'b0}}, wordLow};
        end
    end

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            state     <= stIdle;
            shiftReg  <= '0;
            bitCount  <= '0;
            chipSel   <= '0;
            sckEnable <= 1'b0;
            pllCs     <= '0;
            loadDone  <= 1'b0;
            loadSel   <= '0;
        end else begin
            loadDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (startValid && startReady) begin
                        chipSel <= startSel;
                        state   <= stStart;
                    end
                end
                stStart: begin
                    // First data bit appears on a fall so the chip sees it on the next rise.
                    if (sckFall) begin
                        shiftReg  <= frameInit;
                        bitCount  <= frameCountBits'(frameBits - 1);
                        sckEnable <= 1'b1;
                        state     <= stShift;
                    end
                end
                stShift: begin
                    if (sckFall) begin
                        shiftReg <= {shiftReg[frameBits-2:0], 1'b0};
                        if (bitCount == '0) begin
                            sckEnable <= 1'b0;
                            pllCs     <= chipSel;
                            state     <= stStrobe;
                        end else begin
                            bitCount <= bitCount - 1'b1;
                        end
                    end
                end
                stStrobe: begin
                    if (sckFall) begin
                        pllCs    <= '0;
                        loadDone <= 1'b1;
                        loadSel  <= chipSel;
                        state    <= stIdle;
                    end
                end
                default: begin
                    sckEnable <= 1'b0;
                    pllCs     <= '0;
                    state     <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ics307Interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module ics307Interface (
    input  wire                      busClk,
    input  wire                      xferDone,
    input  wire [12:0]               addr,
    input  wire ics307Pkg::busWord   dataIn,
    input  wire                      wr0,
    input  wire                      wr1,
    input  wire                      wr2,
    input  wire                      wr3,
    output wire ics307Pkg::busWord   dataOut,
    output wire                      sck,
    output wire                      sdi,
    output wire ics307Pkg::pllSelect pllCs,
    output wire ics307Pkg::pllSelect pllEn,
    output wire ics307Pkg::pllSelect pllReset
);

    import ics307Pkg::*;

    wire           startValid;
    wire           startReady;
    wire pllSelect startSel;
    wire busWord   wordLow;
    wire busWord   wordMid;
    wire busWord   wordHigh;
    wire           loadDone;
    wire pllSelect loadSel;
    wire           sckEnable;
    wire           sckRise;
    wire           sckFall;

    pllRegBank regBank (
        .busClk     (busClk),
        .xferDone   (xferDone),
        .addr       (addr),
        .dataIn     (dataIn),
        .wr0        (wr0),
        .wr1        (wr1),
        .wr2        (wr2),
        .wr3        (wr3),
        .startReady (startReady),
        .loadDone   (loadDone),
        .loadSel    (loadSel),
        .dataOut    (dataOut),
        .pllEn      (pllEn),
        .pllReset   (pllReset),
        .startValid (startValid),
        .startSel   (startSel),
        .wordLow    (wordLow),
        .wordMid    (wordMid),
        .wordHigh   (wordHigh)
    );

    sckGenerator sckGen (
        .busClk    (busClk),
        .xferDone  (xferDone),
        .sckEnable (sckEnable),
        .sck       (sck),
        .sckRise   (sckRise),
        .sckFall   (sckFall)
    );

    ics307Serializer serializer (
        .busClk     (busClk),
        .xferDone   (xferDone),
        .startValid (startValid),
        .startSel   (startSel),
        .wordLow    (wordLow),
        .wordMid    (wordMid),
        .wordHigh   (wordHigh),
        .sckRise    (sckRise),
        .sckFall    (sckFall),
        .startReady (startReady),
        .sckEnable  (sckEnable),
        .sdi        (sdi),
        .pllCs      (pllCs),
        .loadDone   (loadDone),
        .loadSel    (loadSel)
    );

endmodule

`default_nettype wire

// ==== verif/ics307Model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ics307Model (
    input  wire                      sck,
    input  wire                      sdi,
    input  wire ics307Pkg::pllSelect pllCs,
    output ics307Pkg::pllFrame       frame,
    output ics307Pkg::pllSelect      frameSel,
    output logic [31:0]              frameCount,
    output logic [31:0]              frameRises
);

    import ics307Pkg::*;

    pllFrame     shiftIn;
    pllSelect    csLast;
    logic [31:0] riseCount;
    event        frameSeen;

    initial begin
        shiftIn    = '0;
        csLast     = '0;
        riseCount  = '0;
        frame      = '0;
        frameSel   = '0;
        frameCount = '0;
        frameRises = '0;
    end

    // The chips sample data on the rising serial clock.
    always @(posedge sck) begin
        shiftIn   = {shiftIn[frameBits-2:0], sdi};
        riseCount = riseCount + 1;
    end

    // A rising chip select latches whatever has been shifted in so far.
    always @(pllCs) begin
        if ((pllCs & ~csLast) != '0) begin
            frame      = shiftIn;
            frameSel   = pllCs;
            frameRises = riseCount;   // Clock count of this frame alone.
            riseCount  = '0;
            frameCount = frameCount + 1;
            -> frameSeen;
        end
        csLast = pllCs;
    end

endmodule

`default_nettype wire

// ==== verif/ics307Tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ics307Tb;

    import ics307Pkg::*;

    localparam int cycleLimit = 5000;   // Five loads of about 540 cycles plus register traffic.
    localparam logic [19:0] lanePatterns = 20'h5861F;

    logic        busClk;
    logic        xferDone;
    logic [12:0] addr;
    busWord      dataIn;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    wire busWord   dataOut;
    wire           sck;
    wire           sdi;
    wire pllSelect pllCs;
    wire pllSelect pllEn;
    wire pllSelect pllReset;
    wire pllFrame  frame;
    wire pllSelect frameSel;
    wire [31:0]    frameCount;
    wire [31:0]    frameRises;
    int          errorCount;
    int          loadsChecked;
    int          cycleCount = 0;
    busWord      shadow [pllCount][3];   // Expected low, mid and high words per chip.

    ics307Interface uut (
        .busClk   (busClk),
        .xferDone (xferDone),
        .addr     (addr),
        .dataIn   (dataIn),
        .wr0      (wr0),
        .wr1      (wr1),
        .wr2      (wr2),
        .wr3      (wr3),
        .dataOut  (dataOut),
        .sck      (sck),
        .sdi      (sdi),
        .pllCs    (pllCs),
        .pllEn    (pllEn),
        .pllReset (pllReset)
    );

    ics307Model chips (
        .sck        (sck),
        .sdi        (sdi),
        .pllCs      (pllCs),
        .frame      (frame),
        .frameSel   (frameSel),
        .frameCount (frameCount),
        .frameRises (frameRises)
    );

    always #10 busClk = ~busClk;

    always @(posedge busClk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d busClk cycles, a load never completed.", cycleCount);
            $display("Errors: %0d, loads checked: %0d", errorCount, loadsChecked);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [12:0] regAddr(input logic [1:0] pll, input logic [2:0] off);
        return {pllSpaceBase, pll, off};
    endfunction

    function automatic busWord mergeLanes(input busWord old, input busWord wrData,
                                          input logic [3:0] lanes);
        busWord merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) merged[8*b +: 8] = wrData[8*b +: 8];
        end
        return merged;
    endfunction

    // High word, mid word, the zero gap, then the low word, sent MSB first.
    function automatic pllFrame expectedFrame(input int pll);
        return {shadow[pll][2], shadow[pll][1], {36{1'b0}}, shadow[pll][0]};
    endfunction

    task automatic compareWord(input string name, input busWord expected, input busWord actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compareFrame(input string name, input pllFrame expected, input pllFrame actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compareSelect(input string name, input pllSelect expected,
                                 input pllSelect actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the edge that takes the write.
    task automatic busWrite(input logic [12:0] a, input busWord d, input logic [3:0] lanes);
        addr   = a;
        dataIn = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(posedge busClk);
        #1;
        {wr3, wr2, wr1, wr0} = 4'h0;
    endtask

    task automatic busRead(input logic [12:0] a, output busWord d);
        addr = a;
        #9;
        d = dataOut;   // Mid cycle, away from the rising edge.
        @(posedge busClk);
        #1;
    endtask

    task automatic checkRead(input logic [12:0] a, input busWord expected);
        busWord got;
        busRead(a, got);
        compareWord("dataOut", expected, got);
    endtask

    task automatic writeConfig(input int pll, input int off, input busWord d,
                               input logic [3:0] lanes);
        busWrite(regAddr(pll, off), d, lanes);
        shadow[pll][off] = mergeLanes(shadow[pll][off], d, lanes);
    endtask

    task automatic waitLoad(input int pll);
        if (frameCount == loadsChecked) begin
            @(chips.frameSeen);
        end
        loadsChecked++;
        compareFrame("frame", expectedFrame(pll), frame);
        compareSelect("pllCs", pllSelect'(1) << pll, frameSel);
        compareWord("sckRises", frameBits, frameRises);
        while (pllCs != '0) begin
            @(posedge busClk);
            #1;
        end
        @(posedge busClk);   // Done flag lands one cycle after the strobe ends.
        #1;
    endtask

    task automatic testResetState();
        for (int p = 0; p < pllCount; p++) begin
            for (int off = 0; off < 5; off++) begin
                checkRead(regAddr(p, off), '0);
            end
        end
        compareBit("sck", 1'b0, sck);
        compareBit("sdi", 1'b0, sdi);
        compareSelect("pllCs", '0, pllCs);
        compareSelect("pllEn", '0, pllEn);
        compareSelect("pllReset", '0, pllReset);
    endtask

    task automatic testByteLanes();
        for (int p = 0; p < pllCount; p++) begin
            for (int off = 0; off < 3; off++) begin
                for (int k = 0; k < 5; k++) begin
                    writeConfig(p, off, $urandom(), lanePatterns[4*k +: 4]);
                    checkRead(regAddr(p, off), shadow[p][off]);
                end
            end
        end
    endtask

    task automatic testControlWord();
        for (int p = 0; p < pllCount; p++) begin
            busWrite(regAddr(p, regControl), 32'h3, 4'h1);   // Done bit is set in the data too.
            compareSelect("pllEn", pllSelect'(1) << p, pllEn);
            compareSelect("pllReset", '0, pllReset);
            checkRead(regAddr(p, regControl), 32'h1);
            busWrite(regAddr(p, regControl), 32'h6, 4'h1);
            compareSelect("pllEn", '0, pllEn);
            compareSelect("pllReset", pllSelect'(1) << p, pllReset);
            checkRead(regAddr(p, regControl), 32'h4);
            busWrite(regAddr(p, regControl), 32'h0, 4'h1);
        end
        busWrite({~pllSpaceBase, 5'h0}, $urandom(), 4'hF);
        checkRead({~pllSpaceBase, 5'h0}, '0);
        checkRead(regAddr(0, regBitsLow), shadow[0][0]);
        checkRead(regAddr(3, regBitsLow), '0);   // No chip behind index 3.
    endtask

    task automatic testSingleLoad();
        busWrite(regAddr(1, regXfer), '0, 4'h8);
        waitLoad(1);
        checkRead(regAddr(0, regControl), '0);
        checkRead(regAddr(1, regControl), 32'h2);
        checkRead(regAddr(2, regControl), '0);
    endtask

    task automatic testQueuedLoads();
        busWrite(regAddr(2, regXfer), '0, 4'h8);
        busWrite(regAddr(1, regXfer), '0, 4'h8);
        busWrite(regAddr(0, regXfer), '0, 4'h8);
        waitLoad(2);   // Accepted while it was the only request.
        waitLoad(0);
        waitLoad(1);
        for (int p = 0; p < pllCount; p++) begin
            checkRead(regAddr(p, regControl), 32'h2);
        end
    endtask

    task automatic testDoneClearing();
        writeConfig(0, regBitsMid, $urandom(), 4'hF);
        busWrite(regAddr(0, regXfer), '0, 4'h8);
        checkRead(regAddr(0, regControl), '0);
        waitLoad(0);
        checkRead(regAddr(0, regControl), 32'h2);
        checkRead(regAddr(1, regControl), 32'h2);
    endtask

    initial begin
        void'($urandom(80544));
        busClk       = 1'b0;
        xferDone     = 1'b1;
        addr         = '0;
        dataIn       = '0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        errorCount   = 0;
        loadsChecked = 0;
        for (int p = 0; p < pllCount; p++) begin
            for (int off = 0; off < 3; off++) begin
                shadow[p][off] = '0;
            end
        end
        repeat (5) @(posedge busClk);
        #1;
        xferDone = 1'b0;
        testResetState();
        testByteLanes();
        testControlWord();
        testSingleLoad();
        testQueuedLoads();
        testDoneClearing();
        $display("Errors: %0d, loads checked: %0d", errorCount, loadsChecked);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ics307Prog.f ====
rtl/ics307Pkg.sv
rtl/pllRegBank.sv
rtl/sckGenerator.sv
rtl/ics307Serializer.sv
rtl/ics307Interface.sv
verif/ics307Model.sv
verif/ics307Tb.sv
